/* hdl/bumpy_pkg.sv */
package bumpy_pkg;

	// movement states of the piece
	typedef enum logic [2:0] {
		S_RESET,
		S_IDLE,
		S_LEFT,
		S_RIGHT,
		S_DOWN,
		S_UP,
		S_DIE
	} move_state_t;

	// what a map tile does to the piece
	typedef enum logic [1:0] {
		TILE_FREE,
		TILE_STEP,
		TILE_TELEPORT,
		TILE_SPIKE
	} tile_kind_t;

	typedef logic [3:0] edge_code_t; // one-hot contact side
	localparam edge_code_t EDGE_BOTTOM = 4'b0001;
	localparam edge_code_t EDGE_RIGHT  = 4'b0010;
	localparam edge_code_t EDGE_TOP    = 4'b0100;
	localparam edge_code_t EDGE_LEFT   = 4'b1000;

	typedef logic signed [10:0] pixel_t;  // screen coordinate
	typedef logic signed [31:0] pos_fp_t; // 1/64 pixel units
	typedef logic [3:0] tile_idx_t;       // map column or row

	localparam int FP_SHIFT = 6; // fraction bits of pos_fp_t

	// world geometry in pixels and tiles
	localparam int TILE_PX = 64;
	localparam int BUMPY_PX = 16;
	localparam int MAP_COLS = 10;
	localparam int MAP_ROWS = 8;
	localparam int CENTER_OFS_PX = 24; // piece centred inside a tile

endpackage

/* hdl/collide_if.sv */
interface collide_if;
	import bumpy_pkg::*;

	logic step_hit;
	logic free_hit;
	logic teleport_hit;
	logic spike_hit;
	edge_code_t hit_edge;     // side of the winning probe
	tile_idx_t teleport_col;
	tile_idx_t teleport_row;

	modport detector(output step_hit, free_hit, teleport_hit, spike_hit,
		hit_edge, teleport_col, teleport_row);

	modport mover(input step_hit, free_hit, teleport_hit, hit_edge,
		teleport_col, teleport_row);

	modport steer(input spike_hit, hit_edge);

endinterface

/* hdl/tile_map.sv */
module tile_map (
	input bumpy_pkg::tile_idx_t col_q [4],
	input bumpy_pkg::tile_idx_t row_q [4],
	output bumpy_pkg::tile_kind_t kind [4],
	output bumpy_pkg::tile_idx_t tgt_col [4],
	output bumpy_pkg::tile_idx_t tgt_row [4]
);
	import bumpy_pkg::*;

	// the one teleport and where it sends the piece
	localparam tile_idx_t TELE_COL = 4'd0;
	localparam tile_idx_t TELE_ROW = 4'd3;
	localparam tile_idx_t DEST_COL = 4'd5;
	localparam tile_idx_t DEST_ROW = 4'd1;

	localparam tile_idx_t SPIKE_COL = 4'd5;
	localparam tile_idx_t SPIKE_ROW = 4'd4;

	localparam tile_idx_t FLOOR_ROW = tile_idx_t'(MAP_ROWS - 1);

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			tgt_col[i] = '0;
			tgt_row[i] = '0;
			if (col_q[i] >= tile_idx_t'(MAP_COLS) || row_q[i] >= tile_idx_t'(MAP_ROWS)) begin
				kind[i] = TILE_STEP; // outside the world acts as wall
			end
			else if (row_q[i] == FLOOR_ROW) begin
				kind[i] = TILE_STEP; // solid floor
			end
			else begin
				case ({col_q[i], row_q[i]})
					{TELE_COL, TELE_ROW}: begin
						kind[i] = TILE_TELEPORT;
						tgt_col[i] = DEST_COL;
						tgt_row[i] = DEST_ROW;
					end
					{SPIKE_COL, SPIKE_ROW}: kind[i] = TILE_SPIKE;
					default: kind[i] = TILE_FREE;
				endcase
			end
		end
	end

endmodule

/* hdl/tile_collide.sv */
module tile_collide (
	input logic clk,
	input logic resetN,
	input bumpy_pkg::pixel_t offset_x,
	input bumpy_pkg::pixel_t offset_y,
	collide_if.detector col
);
	import bumpy_pkg::*;

	localparam int TILE_SHIFT = $clog2(TILE_PX);
	localparam int SCREEN_W = 640;
	localparam int SCREEN_H = 480;
	localparam int HALF_PX = BUMPY_PX / 2;

	// probe slots in priority order
	localparam int P_BOTTOM = 0;
	localparam int P_LEFT = 1;
	localparam int P_RIGHT = 2;
	localparam int P_TOP = 3;
	localparam edge_code_t PROBE_EDGE [4] = '{EDGE_BOTTOM, EDGE_LEFT, EDGE_RIGHT, EDGE_TOP};

	pixel_t probe_x [4];
	pixel_t probe_y [4];
	logic off_map [4];
	tile_idx_t col_q [4];
	tile_idx_t row_q [4];
	tile_kind_t kind [4];
	tile_idx_t tgt_col [4];
	tile_idx_t tgt_row [4];

	logic hit_found;
	tile_kind_t sel_kind;
	edge_code_t sel_edge;
	tile_idx_t sel_col;
	tile_idx_t sel_row;

	// sample points just outside each side of the 16x16 piece
	always_comb begin
		probe_x[P_BOTTOM] = offset_x + pixel_t'(HALF_PX);
		probe_y[P_BOTTOM] = offset_y + pixel_t'(BUMPY_PX);
		probe_x[P_LEFT] = offset_x - pixel_t'(1);
		probe_y[P_LEFT] = offset_y + pixel_t'(HALF_PX);
		probe_x[P_RIGHT] = offset_x + pixel_t'(BUMPY_PX);
		probe_y[P_RIGHT] = offset_y + pixel_t'(HALF_PX);
		probe_x[P_TOP] = offset_x + pixel_t'(HALF_PX);
		probe_y[P_TOP] = offset_y - pixel_t'(1);
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			off_map[i] = (probe_x[i] < 0) || (probe_x[i] >= pixel_t'(SCREEN_W)) ||
				(probe_y[i] < 0) || (probe_y[i] >= pixel_t'(SCREEN_H));
			// all ones is never a valid tile, so the map answers with a wall
			col_q[i] = off_map[i] ? '1 : tile_idx_t'(probe_x[i] >>> TILE_SHIFT);
			row_q[i] = off_map[i] ? '1 : tile_idx_t'(probe_y[i] >>> TILE_SHIFT);
		end
	end

	tile_map u_map (
		.col_q(col_q),
		.row_q(row_q),
		.kind(kind),
		.tgt_col(tgt_col),
		.tgt_row(tgt_row)
	);

	// first non-free probe wins
	always_comb begin
		hit_found = 1'b0;
		sel_kind = TILE_FREE;
		sel_edge = EDGE_BOTTOM; // reported when nothing is touched
		sel_col = '0;
		sel_row = '0;
		for (int i = 0; i < 4; i++) begin
			if (!hit_found && kind[i] != TILE_FREE) begin
				hit_found = 1'b1;
				sel_kind = kind[i];
				sel_edge = PROBE_EDGE[i];
				sel_col = tgt_col[i];
				sel_row = tgt_row[i];
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			col.step_hit <= 1'b0;
			col.free_hit <= 1'b0;
			col.teleport_hit <= 1'b0;
			col.spike_hit <= 1'b0;
			col.hit_edge <= '0;
		end
		else begin
			col.step_hit <= hit_found && (sel_kind == TILE_STEP);
			col.free_hit <= !hit_found;
			col.teleport_hit <= hit_found && (sel_kind == TILE_TELEPORT);
			col.spike_hit <= hit_found && (sel_kind == TILE_SPIKE);
			col.hit_edge <= sel_edge;
		end
	end

	always_ff @(posedge clk) begin
		col.teleport_col <= sel_col;
		col.teleport_row <= sel_row;
	end

endmodule

/* hdl/bumpy_fsm.sv */
module bumpy_fsm (
	input logic clk,
	input logic resetN,
	input logic key_left,
	input logic key_right,
	input logic key_up,
	input logic key_down,
	input logic restart,
	collide_if.steer col,
	output bumpy_pkg::move_state_t state,
	output logic dead
);
	import bumpy_pkg::*;

	move_state_t state_nxt;
	logic spike_contact;

	// spikes point up, so brushing the underside with the top probe is harmless
	assign spike_contact = col.spike_hit && (col.hit_edge != EDGE_TOP);

	always_comb begin
		state_nxt = state;
		case (state)
			S_RESET: begin
				// flags still describe the old spot right after a restart
				if (!col.spike_hit)
					state_nxt = S_IDLE;
			end

			S_DIE: begin
				if (restart)
					state_nxt = S_RESET;
			end

			default: begin
				if (spike_contact)
					state_nxt = S_DIE;
				else if (key_down)
					state_nxt = S_DOWN; // down beats up beats left beats right
				else if (key_up)
					state_nxt = S_UP;
				else if (key_left)
					state_nxt = S_LEFT;
				else if (key_right)
					state_nxt = S_RIGHT;
				else
					state_nxt = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= S_RESET;
			dead <= 1'b0;
		end
		else begin
			state <= state_nxt;
			dead <= (state_nxt == S_DIE); // tracks state without a lag
		end
	end

endmodule

/* hdl/bumpy_move.sv */
module bumpy_move #(
	parameter int SPEED_X = 120,
	parameter int SPEED_Y = 150,
	parameter int JUMP_LIMIT_TILES = 1
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input bumpy_pkg::move_state_t state,
	collide_if.mover col,
	output bumpy_pkg::pixel_t offset_x,
	output bumpy_pkg::pixel_t offset_y
);
	import bumpy_pkg::*;

	localparam pos_fp_t TILE_FP = pos_fp_t'(TILE_PX << FP_SHIFT);
	localparam pos_fp_t CENTER_FP = pos_fp_t'(CENTER_OFS_PX << FP_SHIFT);
	localparam pos_fp_t JUMP_LIMIT = pos_fp_t'(JUMP_LIMIT_TILES) * TILE_FP;
	localparam pos_fp_t VX = pos_fp_t'(SPEED_X);
	localparam pos_fp_t VY = pos_fp_t'(SPEED_Y);

	pos_fp_t pos_x;
	pos_fp_t pos_y;
	pos_fp_t speed_x;
	pos_fp_t speed_y;
	pos_fp_t jump_start_x;
	pos_fp_t jump_start_y;

	logic bottom_step;
	logic bottom_free;
	logic bottom_teleport;

	assign bottom_step = col.step_hit && (col.hit_edge == EDGE_BOTTOM);
	assign bottom_free = col.free_hit && (col.hit_edge == EDGE_BOTTOM);
	assign bottom_teleport = col.teleport_hit && (col.hit_edge == EDGE_BOTTOM);

	// origin of the current jump, the limits are measured from here
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			jump_start_x <= CENTER_FP;
			jump_start_y <= CENTER_FP;
		end
		else if (state == S_RESET) begin
			jump_start_x <= CENTER_FP;
			jump_start_y <= CENTER_FP;
		end
		else if (bottom_step || (state == S_UP && bottom_free)) begin
			jump_start_x <= pos_x;
			jump_start_y <= pos_y;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			speed_y <= '0;
		else begin
			case (state)
				S_RESET, S_DIE: speed_y <= '0;
				S_IDLE, S_LEFT, S_RIGHT: begin
					if (bottom_step && speed_y >= 0)
						speed_y <= -VY; // bounce off the step below
					else if (pos_y < jump_start_y - JUMP_LIMIT && speed_y <= 0)
						speed_y <= VY; // apex reached, come back down
				end
				S_DOWN: speed_y <= VY;
				S_UP: speed_y <= -VY;
				default: speed_y <= speed_y;
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			speed_x <= '0;
		else begin
			case (state)
				S_LEFT: begin
					if (pos_x < jump_start_x - JUMP_LIMIT && speed_x <= 0)
						speed_x <= '0;
					else
						speed_x <= -VX;
				end
				S_RIGHT: begin
					if (pos_x > jump_start_x + JUMP_LIMIT && speed_x >= 0)
						speed_x <= '0;
					else
						speed_x <= VX;
				end
				default: speed_x <= '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pos_x <= CENTER_FP;
			pos_y <= CENTER_FP;
		end
		else if (state == S_RESET) begin
			pos_x <= CENTER_FP;
			pos_y <= CENTER_FP;
		end
		else if (bottom_teleport) begin
			pos_x <= pos_fp_t'(col.teleport_col) * TILE_FP + CENTER_FP;
			pos_y <= pos_fp_t'(col.teleport_row) * TILE_FP + CENTER_FP;
		end
		else if (start_of_frame) begin // integrate once per frame
			pos_x <= pos_x + speed_x;
			pos_y <= pos_y + speed_y;
		end
	end

	assign offset_x = pixel_t'(pos_x >>> FP_SHIFT);
	assign offset_y = pixel_t'(pos_y >>> FP_SHIFT);

endmodule

/* hdl/bumpy_top.sv */
module bumpy_top #(
	parameter int SPEED_X = 120,
	parameter int SPEED_Y = 150,
	parameter int JUMP_LIMIT_TILES = 1
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input logic key_left,
	input logic key_right,
	input logic key_up,
	input logic key_down,
	input logic restart,
	output bumpy_pkg::pixel_t offset_x,
	output bumpy_pkg::pixel_t offset_y,
	output logic dead
);
	import bumpy_pkg::*;

	move_state_t state;
	collide_if col_bus ();

	tile_collide u_collide (
		.clk(clk),
		.resetN(resetN),
		.offset_x(offset_x),
		.offset_y(offset_y),
		.col(col_bus.detector)
	);

	bumpy_fsm u_fsm (
		.clk(clk),
		.resetN(resetN),
		.key_left(key_left),
		.key_right(key_right),
		.key_up(key_up),
		.key_down(key_down),
		.restart(restart),
		.col(col_bus.steer),
		.state(state),
		.dead(dead)
	);

	bumpy_move #(
		.SPEED_X(SPEED_X),
		.SPEED_Y(SPEED_Y),
		.JUMP_LIMIT_TILES(JUMP_LIMIT_TILES)
	) u_move (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.state(state),
		.col(col_bus.mover),
		.offset_x(offset_x),
		.offset_y(offset_y)
	);

endmodule

/* testbench/tb_bumpy.sv */
module tb_bumpy;
	timeunit 1ns;
	timeprecision 1ps;

	import bumpy_pkg::*;

	localparam int CLK_HALF_NS = 4;
	localparam int START_FP = 1536;         // 24 px in 1/64 px
	localparam int SPEED_X = 120;
	localparam int SPEED_Y = 150;
	localparam int X_LIMIT_FP = 5632;       // jump start plus one tile
	localparam int TELE_X_PX = 5 * 64 + 24; // centre of target tile (5,1)
	localparam int TELE_Y_PX = 1 * 64 + 24;
	localparam int TELE_ROW = 3;
	localparam int SPIKE_ROW = 4;
	localparam int FALL_FRAMES = 20;
	localparam int TELE_BOUND = 60;
	localparam int SPIKE_BOUND = 80;
	localparam int DEAD_FRAMES = 5;
	localparam int RIGHT_BOUND = 60;
	localparam int HOLD_FRAMES = 10;
	localparam int SETTLE_CYCLES = 4;       // key to state to speed
	localparam int MAX_FRAME_CYCLES = 11;   // pulse plus the longest gap
	localparam int MARGIN_CYCLES = 400;
	localparam int ALL_FRAMES = FALL_FRAMES + TELE_BOUND + SPIKE_BOUND + DEAD_FRAMES +
		RIGHT_BOUND;
	localparam int WATCHDOG_NS = (ALL_FRAMES * MAX_FRAME_CYCLES + MARGIN_CYCLES) *
		2 * CLK_HALF_NS;

	logic clk;
	logic resetN;
	logic start_of_frame;
	logic key_left;
	logic key_right;
	logic key_up;
	logic key_down;
	logic restart;
	pixel_t offset_x;
	pixel_t offset_y;
	logic dead;

	int error_count;
	logic [31:0] lfsr_state;
	int x_fp;   // expected position in 1/64 px
	int y_fp;
	int snap_x; // output one clock after the frame pulse
	int snap_y;

	bumpy_top #(
		.SPEED_X(SPEED_X),
		.SPEED_Y(SPEED_Y),
		.JUMP_LIMIT_TILES(1)
	) u_dut (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.key_left(key_left),
		.key_right(key_right),
		.key_up(key_up),
		.key_down(key_down),
		.restart(restart),
		.offset_x(offset_x),
		.offset_y(offset_y),
		.dead(dead)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_HALF_NS) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int frame_gap();
		logic [2:0] bits;
		bits = '0;
		for (int i = 0; i < 3; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			bits = {bits[1:0], lfsr_state[0]};
		end
		return 3 + int'(bits); // 3 to 10 cycles
	endfunction

	function automatic int to_pixel(input int fp);
		return fp >>> 6;
	endfunction

	// tile row under the bottom probe
	function automatic int bottom_row(input int y_px);
		return (y_px + 16) >>> 6;
	endfunction

	task automatic check_value(input string test, input string what, input int expected,
		input int actual);
		assert (actual == expected)
		else begin
			$display("ERR %s: %s expected %0d actual %0d", test, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_failure(input string test, input string what);
		$display("%s: %s", test, what);
		error_count++;
	endtask

	task automatic check_position(input string test);
		check_value(test, "offset_x", to_pixel(x_fp), int'(offset_x));
		check_value(test, "offset_y", to_pixel(y_fp), int'(offset_y));
	endtask

	task automatic apply_reset();
		resetN = 1'b0;
		repeat (10) @(negedge clk);
		resetN = 1'b1;
		x_fp = START_FP;
		y_fp = START_FP;
	endtask

	task automatic run_frame();
		int gap;
		gap = frame_gap();
		start_of_frame = 1'b1;
		@(negedge clk);
		start_of_frame = 1'b0;
		snap_x = int'(offset_x);
		snap_y = int'(offset_y);
		repeat (gap) @(negedge clk);
	endtask

	task automatic reset_values();
		apply_reset();
		check_position("reset");
		check_value("reset", "dead", 0, int'(dead));
	endtask

	task automatic idle_hold();
		repeat (50) begin
			@(negedge clk);
			check_position("idle");
		end
	endtask

	task automatic fall_down();
		key_down = 1'b1;
		repeat (SETTLE_CYCLES) @(negedge clk);
		for (int n = 0; n < FALL_FRAMES; n++) begin
			y_fp += SPEED_Y;
			run_frame();
			check_value("fall", "x", to_pixel(x_fp), snap_x);
			check_value("fall", "y", to_pixel(y_fp), snap_y);
			assert (bottom_row(snap_y) < TELE_ROW)
			else report_failure("fall", "bottom probe reached the teleport row too early");
		end
	endtask

	task automatic teleport_jump();
		logic landed;
		landed = 1'b0;
		for (int n = 0; n < TELE_BOUND && !landed; n++) begin
			y_fp += SPEED_Y;
			run_frame();
			if (bottom_row(to_pixel(y_fp)) >= TELE_ROW) begin // column 0 teleport
				x_fp = TELE_X_PX * 64;
				y_fp = TELE_Y_PX * 64;
			end
			check_position("teleport");
			landed = int'(offset_x) == TELE_X_PX && int'(offset_y) == TELE_Y_PX;
		end
		assert (landed)
		else report_failure("teleport", "the piece never reached the teleport tile");
	endtask

	task automatic spike_restart();
		logic expect_dead;
		logic recovered;
		expect_dead = 1'b0;
		for (int n = 0; n < SPIKE_BOUND && !dead; n++) begin
			y_fp += SPEED_Y;
			run_frame();
			expect_dead = bottom_row(to_pixel(y_fp)) >= SPIKE_ROW;
			check_position("spike");
			check_value("spike", "dead", int'(expect_dead), int'(dead));
		end
		assert (dead)
		else report_failure("spike", "dead never rose on the spike tile");
		key_down = 1'b0;
		for (int n = 0; n < DEAD_FRAMES; n++) begin
			run_frame();
			check_position("spike");
			check_value("spike", "dead", 1, int'(dead));
		end

		restart = 1'b1;
		@(negedge clk);
		restart = 1'b0;
		x_fp = START_FP;
		y_fp = START_FP;
		recovered = 1'b0;
		for (int i = 0; i < 20 && !recovered; i++) begin
			@(negedge clk);
			recovered = !dead && int'(offset_x) == to_pixel(x_fp) &&
				int'(offset_y) == to_pixel(y_fp);
		end
		assert (recovered)
		else report_failure("restart", "the piece did not return to the start after restart");
		check_position("restart");
		check_value("restart", "dead", 0, int'(dead));
	endtask

	task automatic right_limit();
		int held;
		held = 0;
		apply_reset();
		key_right = 1'b1;
		repeat (SETTLE_CYCLES) @(negedge clk);
		for (int n = 0; n < RIGHT_BOUND && held < HOLD_FRAMES; n++) begin
			if (x_fp > X_LIMIT_FP)
				held++; // past the limit the piece stops
			else
				x_fp += SPEED_X;
			run_frame();
			check_value("right", "x", to_pixel(x_fp), snap_x);
			check_value("right", "y", to_pixel(y_fp), snap_y);
		end
		key_right = 1'b0;
	endtask

	initial begin
		resetN = 1'b0;
		start_of_frame = 1'b0;
		key_left = 1'b0;
		key_right = 1'b0;
		key_up = 1'b0;
		key_down = 1'b0;
		restart = 1'b0;
		error_count = 0;
		lfsr_state = 32'h4fa9_dbfd;
		x_fp = START_FP;
		y_fp = START_FP;
		snap_x = 0;
		snap_y = 0;

		reset_values();
		idle_hold();
		fall_down();
		teleport_jump();
		spike_restart();
		right_limit();

		$display("checks done, %0d errors", error_count);
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* files.f */
hdl/bumpy_pkg.sv
hdl/collide_if.sv
hdl/tile_map.sv
hdl/tile_collide.sv
hdl/bumpy_fsm.sv
hdl/bumpy_move.sv
hdl/bumpy_top.sv
testbench/tb_bumpy.sv

/* Makefile */
# Verilator build and run for the bumpy testbench
VERILATOR ?= verilator
TOP       ?= tb_bumpy
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
